/* hw/exu_macros.svh */
// Widths and constants shared by the execute-stage package and RTL; include wherever needed
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// --------------------------------------------------
// Datapath widths
// --------------------------------------------------

// Data and address width
`define EXU_XLEN 32

// Scoreboard transaction ID
`define EXU_TRANS_ID_BITS 3

// CSR address field of the instruction
`define EXU_CSR_ADDR_BITS 12

// Operator encoding and exception cause widths
`define EXU_OP_BITS 5
`define EXU_CAUSE_BITS 4

// --------------------------------------------------
// Exception causes
// --------------------------------------------------
`define EXU_CAUSE_INSTR_MISALIGNED 4'd0

`endif

/* hw/exu_pkg.sv */
// Types shared by the execute-stage modules; import the package where its types are needed
`include "exu_macros.svh"

package exu_pkg;

    // --------------------------------------------------
    // Operators
    // --------------------------------------------------
    typedef enum logic [`EXU_OP_BITS-1:0] {
        // Integer ALU
        ADD,
        SUB,
        XORL,
        ORL,
        ANDL,
        SLL,
        SRL,
        SRA,
        SLTS,
        SLTU,
        // Branch comparisons
        EQ,
        NE,
        LTS,
        GES,
        LTU,
        GEU,
        // Jumps and CSR access
        JALR,
        CSR_RW
    } fu_op_e;

    // Issued operation, shared by all fixed-latency units
    typedef struct packed {
        fu_op_e                         operator;
        logic [`EXU_XLEN-1:0]          operand_a;
        logic [`EXU_XLEN-1:0]          operand_b;
        logic [`EXU_XLEN-1:0]          imm;
        logic [`EXU_TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    // --------------------------------------------------
    // Branch prediction and resolution
    // --------------------------------------------------
    typedef struct packed {
        logic                 taken;
        logic [`EXU_XLEN-1:0] predict_address;
    } branch_predict_t;

    typedef struct packed {
        logic                 valid;
        logic [`EXU_XLEN-1:0] pc;
        logic [`EXU_XLEN-1:0] target_address;
        logic                 is_taken;
        logic                 is_mispredict;
    } bp_resolve_t;

    // Exception reported with the writeback
    typedef struct packed {
        logic                       valid;
        logic [`EXU_CAUSE_BITS-1:0] cause;
        logic [`EXU_XLEN-1:0]       tval;
    } exception_t;

endpackage

/* hw/exu_alu.sv */
// Integer ALU with input silencing; also produces the comparison result for branches
`include "exu_macros.svh"

module exu_alu (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 alu_valid_i,
    input  logic                 branch_valid_i,
    input  exu_pkg::fu_data_t    fu_data_i,
    output logic [`EXU_XLEN-1:0] result_o,
    output logic                 branch_res_o
);
    import exu_pkg::*;

    localparam int unsigned SHAMT_BITS = $clog2(`EXU_XLEN);

    fu_data_t              alu_data;
    logic [SHAMT_BITS-1:0] shamt;
    logic                  signed_lt;
    logic                  unsigned_lt;

    // Operands stay at zero while neither strobe is high
    assign alu_data = (alu_valid_i | branch_valid_i) ? fu_data_i : '0;

    assign shamt       = alu_data.operand_b[SHAMT_BITS-1:0];
    assign signed_lt   = $signed(alu_data.operand_a) < $signed(alu_data.operand_b);
    assign unsigned_lt = alu_data.operand_a < alu_data.operand_b;

    // --------------------------------------------------
    // Operator result
    // --------------------------------------------------
    always_comb begin
        result_o = '0;
        case (alu_data.operator)
            ADD:  result_o = alu_data.operand_a + alu_data.operand_b;
            SUB:  result_o = alu_data.operand_a - alu_data.operand_b;
            XORL: result_o = alu_data.operand_a ^ alu_data.operand_b;
            ORL:  result_o = alu_data.operand_a | alu_data.operand_b;
            ANDL: result_o = alu_data.operand_a & alu_data.operand_b;
            SLL:  result_o = alu_data.operand_a << shamt;
            SRL:  result_o = alu_data.operand_a >> shamt;
            SRA:  result_o = $unsigned($signed(alu_data.operand_a) >>> shamt);
            SLTS: result_o = {{(`EXU_XLEN-1){1'b0}}, signed_lt};
            SLTU: result_o = {{(`EXU_XLEN-1){1'b0}}, unsigned_lt};
            default: result_o = '0;
        endcase
    end

    // --------------------------------------------------
    // Branch comparison
    // --------------------------------------------------
    always_comb begin
        branch_res_o = 1'b0;
        case (alu_data.operator)
            EQ:  branch_res_o = (alu_data.operand_a == alu_data.operand_b);
            NE:  branch_res_o = (alu_data.operand_a != alu_data.operand_b);
            LTS: branch_res_o = signed_lt;
            GES: branch_res_o = ~signed_lt;
            LTU: branch_res_o = unsigned_lt;
            GEU: branch_res_o = ~unsigned_lt;
            default: branch_res_o = 1'b0;
        endcase
    end

    // Issue logic never targets the ALU and the branch unit together
    strobe_exclusive_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(alu_valid_i && branch_valid_i))
        else $error("ALU and branch strobes high in the same cycle");

endmodule

/* hw/exu_branch_unit.sv */
// Branch unit resolving conditional branches and JALR against the front-end prediction
`include "exu_macros.svh"

module exu_branch_unit (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     branch_valid_i,
    input  logic                     fu_valid_i,
    input  exu_pkg::fu_data_t        fu_data_i,
    input  logic [`EXU_XLEN-1:0]     pc_i,
    input  logic                     is_compressed_i,
    input  exu_pkg::branch_predict_t branch_predict_i,
    input  logic                     branch_comp_res_i,
    output logic [`EXU_XLEN-1:0]     branch_result_o,
    output exu_pkg::bp_resolve_t     resolved_branch_o,
    output logic                     resolve_branch_o,
    output exu_pkg::exception_t      branch_exception_o
);
    import exu_pkg::*;

    logic                 is_jalr;
    logic                 actual_taken;
    logic [`EXU_XLEN-1:0] next_pc;
    logic [`EXU_XLEN-1:0] target_base;
    logic [`EXU_XLEN-1:0] jump_target;

    // --------------------------------------------------
    // Target and link address
    // --------------------------------------------------
    assign is_jalr = (fu_data_i.operator == JALR);

    // Fall-through depends on the instruction length
    assign next_pc = pc_i + (is_compressed_i ? `EXU_XLEN'd2 : `EXU_XLEN'd4);

    // JALR jumps relative to rs1 and drops bit 0
    assign target_base = is_jalr ? fu_data_i.operand_a : pc_i;
    assign jump_target = (target_base + fu_data_i.imm) & ~`EXU_XLEN'd1;

    assign actual_taken = is_jalr | branch_comp_res_i;

    // Link result is always the fall-through address
    assign branch_result_o = next_pc;

    // --------------------------------------------------
    // Resolution and misprediction
    // --------------------------------------------------
    always_comb begin
        resolved_branch_o                = '0;
        resolved_branch_o.pc             = pc_i;
        resolved_branch_o.target_address = next_pc;
        resolve_branch_o                 = 1'b0;
        branch_exception_o               = '0;

        if (branch_valid_i) begin
            resolve_branch_o                 = 1'b1;
            resolved_branch_o.valid          = 1'b1;
            resolved_branch_o.is_taken       = actual_taken;
            resolved_branch_o.target_address = actual_taken ? jump_target : next_pc;
            resolved_branch_o.is_mispredict  =
                (actual_taken != branch_predict_i.taken) ||
                (actual_taken && (jump_target != branch_predict_i.predict_address));

            // Taken target must be word aligned
            if (actual_taken && jump_target[1]) begin
                branch_exception_o.valid = 1'b1;
                branch_exception_o.cause = `EXU_CAUSE_INSTR_MISALIGNED;
                branch_exception_o.tval  = jump_target;
            end
        end else if (fu_valid_i && branch_predict_i.taken) begin
            // A non-branch was predicted taken, so fetch must go back to the fall-through
            resolved_branch_o.valid         = 1'b1;
            resolved_branch_o.is_mispredict = 1'b1;
        end
    end

    // Decode only sends comparisons and JALR to this unit
    branch_op_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        branch_valid_i |-> (fu_data_i.operator inside {EQ, NE, LTS, GES, LTU, GEU, JALR}))
        else $error("Branch strobe with a non-branch operator");

endmodule

/* hw/exu_csr_buffer.sv */
// Single-entry CSR address buffer; holds the address until commit and stalls issue while full
`include "exu_macros.svh"

module exu_csr_buffer (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          flush_i,
    input  logic                          csr_valid_i,
    input  logic                          csr_commit_i,
    input  exu_pkg::fu_data_t             fu_data_i,
    output logic                          csr_ready_o,
    output logic [`EXU_XLEN-1:0]          csr_result_o,
    output logic [`EXU_CSR_ADDR_BITS-1:0] csr_addr_o
);

    logic                          full_q;
    logic [`EXU_CSR_ADDR_BITS-1:0] csr_addr_q;

    // --------------------------------------------------
    // Fill state
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else if (flush_i || csr_commit_i) begin
            full_q <= 1'b0;
        end else if (csr_valid_i) begin
            full_q <= 1'b1;
        end
    end

    // CSR address comes from the immediate field in operand_b
    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            csr_addr_q <= fu_data_i.operand_b[`EXU_CSR_ADDR_BITS-1:0];
        end
    end

    assign csr_addr_o   = csr_addr_q;
    assign csr_ready_o  = ~full_q;
    // Write data goes back to the scoreboard unchanged
    assign csr_result_o = fu_data_i.operand_a;

    // Issue waits for ready, so the single entry is never overwritten
    no_issue_when_full_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        csr_valid_i |-> !full_q)
        else $error("CSR issued while the buffer is full");

    // Commit only follows an earlier CSR issue
    no_commit_when_empty_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        csr_commit_i |-> full_q)
        else $error("CSR commit while the buffer is empty");

endmodule

/* hw/exu_result_mux.sv */
// Writeback multiplexer for the fixed-latency units onto the single scoreboard result port
`include "exu_macros.svh"

module exu_result_mux (
    input  logic                          alu_valid_i,
    input  logic                          branch_valid_i,
    input  logic                          csr_valid_i,
    input  logic [`EXU_TRANS_ID_BITS-1:0] trans_id_i,
    input  logic [`EXU_XLEN-1:0]          alu_result_i,
    input  logic [`EXU_XLEN-1:0]          branch_result_i,
    input  logic [`EXU_XLEN-1:0]          csr_result_i,
    input  logic                          csr_ready_i,
    output logic [`EXU_XLEN-1:0]          flu_result_o,
    output logic [`EXU_TRANS_ID_BITS-1:0] flu_trans_id_o,
    output logic                          flu_valid_o,
    output logic                          flu_ready_o
);

    // --------------------------------------------------
    // Result select
    // --------------------------------------------------
    always_comb begin
        // Link address of the branch unit by default
        flu_result_o = branch_result_i;
        if (alu_valid_i) begin
            flu_result_o = alu_result_i;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result_i;
        end
    end

    // All units finish in the issue cycle, so the ID passes straight through
    assign flu_trans_id_o = trans_id_i;
    assign flu_valid_o    = alu_valid_i | branch_valid_i | csr_valid_i;

    // Only the CSR buffer can stall
    assign flu_ready_o = csr_ready_i;

    // One unit at a time on the shared writeback port
    always_comb begin
        strobe_onehot_a: assert final ($onehot0({alu_valid_i, branch_valid_i, csr_valid_i}))
            else $error("More than one unit strobe high");
    end

endmodule

/* hw/exu_stage.sv */
// Top level of the fixed-latency execute stage; connects ALU, branch unit, CSR buffer and mux
`include "exu_macros.svh"

module exu_stage (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          flush_i,
    input  exu_pkg::fu_data_t             fu_data_i,
    input  logic [`EXU_XLEN-1:0]          pc_i,
    input  logic                          is_compressed_i,
    // Unit strobes
    input  logic                          alu_valid_i,
    input  logic                          branch_valid_i,
    input  exu_pkg::branch_predict_t      branch_predict_i,
    input  logic                          csr_valid_i,
    input  logic                          csr_commit_i,
    // Writeback
    output logic [`EXU_XLEN-1:0]          flu_result_o,
    output logic [`EXU_TRANS_ID_BITS-1:0] flu_trans_id_o,
    output logic                          flu_valid_o,
    output logic                          flu_ready_o,
    output exu_pkg::exception_t           flu_exception_o,
    // Branch resolution and CSR address
    output exu_pkg::bp_resolve_t          resolved_branch_o,
    output logic                          resolve_branch_o,
    output logic [`EXU_CSR_ADDR_BITS-1:0] csr_addr_o
);

    logic [`EXU_XLEN-1:0] alu_result;
    logic                 alu_branch_res;
    logic [`EXU_XLEN-1:0] branch_result;
    logic [`EXU_XLEN-1:0] csr_result;
    logic                 csr_ready;

    exu_alu alu_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .alu_valid_i    (alu_valid_i),
        .branch_valid_i (branch_valid_i),
        .fu_data_i      (fu_data_i),
        .result_o       (alu_result),
        .branch_res_o   (alu_branch_res)
    );

    // Only the ALU can carry a stray taken prediction
    exu_branch_unit branch_unit_inst (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .branch_valid_i     (branch_valid_i),
        .fu_valid_i         (alu_valid_i),
        .fu_data_i          (fu_data_i),
        .pc_i               (pc_i),
        .is_compressed_i    (is_compressed_i),
        .branch_predict_i   (branch_predict_i),
        .branch_comp_res_i  (alu_branch_res),
        .branch_result_o    (branch_result),
        .resolved_branch_o  (resolved_branch_o),
        .resolve_branch_o   (resolve_branch_o),
        .branch_exception_o (flu_exception_o)
    );

    exu_csr_buffer csr_buffer_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .csr_valid_i  (csr_valid_i),
        .csr_commit_i (csr_commit_i),
        .fu_data_i    (fu_data_i),
        .csr_ready_o  (csr_ready),
        .csr_result_o (csr_result),
        .csr_addr_o   (csr_addr_o)
    );

    exu_result_mux result_mux_inst (
        .alu_valid_i     (alu_valid_i),
        .branch_valid_i  (branch_valid_i),
        .csr_valid_i     (csr_valid_i),
        .trans_id_i      (fu_data_i.trans_id),
        .alu_result_i    (alu_result),
        .branch_result_i (branch_result),
        .csr_result_i    (csr_result),
        .csr_ready_i     (csr_ready),
        .flu_result_o    (flu_result_o),
        .flu_trans_id_o  (flu_trans_id_o),
        .flu_valid_o     (flu_valid_o),
        .flu_ready_o     (flu_ready_o)
    );

endmodule

/* bench/exu_checker.sv */
// Checker for the execute stage; predicts each cycle's outputs from the DUT inputs and compares
`include "exu_macros.svh"

module exu_checker (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          flush_i,
    input  exu_pkg::fu_data_t             fu_data_i,
    input  logic [`EXU_XLEN-1:0]          pc_i,
    input  logic                          is_compressed_i,
    input  logic                          alu_valid_i,
    input  logic                          branch_valid_i,
    input  exu_pkg::branch_predict_t      branch_predict_i,
    input  logic                          csr_valid_i,
    input  logic                          csr_commit_i,
    input  logic [`EXU_XLEN-1:0]          flu_result_i,
    input  logic [`EXU_TRANS_ID_BITS-1:0] flu_trans_id_i,
    input  logic                          flu_valid_i,
    input  logic                          flu_ready_i,
    input  exu_pkg::exception_t           flu_exception_i,
    input  exu_pkg::bp_resolve_t          resolved_branch_i,
    input  logic                          resolve_branch_i,
    input  logic [`EXU_CSR_ADDR_BITS-1:0] csr_addr_i,
    output int                            error_count_o,
    output int                            check_count_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import exu_pkg::*;

    // Expected outputs for one cycle; tval is the target when an exception is due
    typedef struct packed {
        logic                 valid;
        logic [`EXU_XLEN-1:0] result;
        logic                 resolve;
        logic                 rb_valid;
        logic [`EXU_XLEN-1:0] target;
        logic                 taken;
        logic                 mispredict;
        logic                 exc_valid;
    } expect_t;

    int                            errors = 0;
    int                            checks = 0;
    logic                          model_full;
    logic [`EXU_CSR_ADDR_BITS-1:0] model_addr;
    expect_t                       want;

    assign error_count_o = errors;
    assign check_count_o = checks;

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic expect_t predict_outputs(
        input fu_data_t             data,
        input logic                 alu_v,
        input logic                 br_v,
        input logic                 csr_v,
        input logic [`EXU_XLEN-1:0] pc,
        input logic                 compressed,
        input branch_predict_t      bp
    );
        expect_t              e;
        logic [`EXU_XLEN-1:0] a;
        logic [`EXU_XLEN-1:0] b;
        logic [`EXU_XLEN-1:0] fall;
        logic [`EXU_XLEN-1:0] jump;
        logic [4:0]           sh;
        logic                 cond;
        e    = '0;
        a    = data.operand_a;
        b    = data.operand_b;
        sh   = b[4:0];
        fall = pc + (compressed ? `EXU_XLEN'd2 : `EXU_XLEN'd4);
        e.valid = alu_v | br_v | csr_v;
        if (alu_v) begin
            case (data.operator)
                ADD:  e.result = a + b;
                SUB:  e.result = a - b;
                XORL: e.result = a ^ b;
                ORL:  e.result = a | b;
                ANDL: e.result = a & b;
                SLL:  e.result = a << sh;
                SRL:  e.result = a >> sh;
                SRA:  e.result = $unsigned($signed(a) >>> sh);
                SLTS: e.result = {{(`EXU_XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
                SLTU: e.result = {{(`EXU_XLEN-1){1'b0}}, (a < b)};
                default: e.result = '0;
            endcase
            // Stray taken prediction on a non-branch sends fetch to the fall-through
            if (bp.taken) begin
                e.rb_valid   = 1'b1;
                e.mispredict = 1'b1;
                e.target     = fall;
            end
        end else if (csr_v) begin
            e.result = a;
        end else if (br_v) begin
            case (data.operator)
                EQ:   cond = (a == b);
                NE:   cond = (a != b);
                LTS:  cond = ($signed(a) < $signed(b));
                GES:  cond = ($signed(a) >= $signed(b));
                LTU:  cond = (a < b);
                GEU:  cond = (a >= b);
                JALR: cond = 1'b1;
                default: cond = 1'b0;
            endcase
            if (data.operator == JALR) begin
                jump = (a + data.imm) & ~`EXU_XLEN'd1;
            end else begin
                jump = pc + data.imm;
            end
            e.result     = fall;
            e.resolve    = 1'b1;
            e.rb_valid   = 1'b1;
            e.taken      = cond;
            e.target     = cond ? jump : fall;
            e.mispredict = (cond != bp.taken) || (cond && (jump != bp.predict_address));
            e.exc_valid  = cond && jump[1];
        end
        return e;
    endfunction

    task automatic check_value(
        input string                name,
        input logic [`EXU_XLEN-1:0] got,
        input logic [`EXU_XLEN-1:0] exp_value
    );
        checks++;
        if (got !== exp_value) begin
            errors++;
            $display("ERROR %s: got %h expected %h at %0t", name, got, exp_value, $time);
        end
    endtask

    // CSR buffer fill state as seen from the issue and commit rules
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            model_full <= 1'b0;
        end else if (flush_i || csr_commit_i) begin
            model_full <= 1'b0;
        end else if (csr_valid_i) begin
            model_full <= 1'b1;
            model_addr <= fu_data_i.operand_b[`EXU_CSR_ADDR_BITS-1:0];
        end
    end

    // --------------------------------------------------
    // Compare on the falling edge
    // --------------------------------------------------
    always @(negedge clk_i) begin
        if (rst_ni) begin
            want = predict_outputs(fu_data_i, alu_valid_i, branch_valid_i, csr_valid_i,
                                   pc_i, is_compressed_i, branch_predict_i);
            check_value("flu_valid_o", 32'(flu_valid_i), 32'(want.valid));
            if (want.valid) begin
                check_value("flu_result_o", flu_result_i, want.result);
                check_value("flu_trans_id_o", 32'(flu_trans_id_i), 32'(fu_data_i.trans_id));
            end
            check_value("resolve_branch_o", 32'(resolve_branch_i), 32'(want.resolve));
            check_value("resolved_branch_o.valid", 32'(resolved_branch_i.valid),
                        32'(want.rb_valid));
            if (want.rb_valid) begin
                check_value("resolved_branch_o.pc", resolved_branch_i.pc, pc_i);
                check_value("resolved_branch_o.target_address",
                            resolved_branch_i.target_address, want.target);
                check_value("resolved_branch_o.is_taken", 32'(resolved_branch_i.is_taken),
                            32'(want.taken));
                check_value("resolved_branch_o.is_mispredict",
                            32'(resolved_branch_i.is_mispredict), 32'(want.mispredict));
            end
            check_value("flu_exception_o.valid", 32'(flu_exception_i.valid),
                        32'(want.exc_valid));
            if (want.exc_valid) begin
                check_value("flu_exception_o.cause", 32'(flu_exception_i.cause),
                            32'(`EXU_CAUSE_INSTR_MISALIGNED));
                check_value("flu_exception_o.tval", flu_exception_i.tval, want.target);
            end
            check_value("flu_ready_o", 32'(flu_ready_i), 32'(!model_full));
            if (model_full) begin
                check_value("csr_addr_o", 32'(csr_addr_i), 32'(model_addr));
            end
        end
    end

endmodule

/* bench/tb_exu_stage.sv */
// Testbench top for the execute stage; drives LFSR traffic and reports the checker's result
`include "exu_macros.svh"

module tb_exu_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import exu_pkg::*;

    localparam int NUM_CYCLES    = 400;
    localparam int READY_TIMEOUT = 4;

    logic                          clk_i;
    logic                          rst_ni;
    logic                          flush_i;
    fu_data_t                      fu_data_i;
    logic [`EXU_XLEN-1:0]          pc_i;
    logic                          is_compressed_i;
    logic                          alu_valid_i;
    logic                          branch_valid_i;
    branch_predict_t               branch_predict_i;
    logic                          csr_valid_i;
    logic                          csr_commit_i;
    logic [`EXU_XLEN-1:0]          flu_result_o;
    logic [`EXU_TRANS_ID_BITS-1:0] flu_trans_id_o;
    logic                          flu_valid_o;
    logic                          flu_ready_o;
    exception_t                    flu_exception_o;
    bp_resolve_t                   resolved_branch_o;
    logic                          resolve_branch_o;
    logic [`EXU_CSR_ADDR_BITS-1:0] csr_addr_o;
    int                            error_count;
    int                            check_count;
    logic [15:0]                   lfsr_q;
    logic                          csr_pending;
    logic                          timed_out;
    int                            hold_cnt;

    exu_stage exu_stage_inst (.*);

    exu_checker checker_inst (
        .clk_i, .rst_ni, .flush_i, .fu_data_i, .pc_i, .is_compressed_i,
        .alu_valid_i, .branch_valid_i, .branch_predict_i, .csr_valid_i, .csr_commit_i,
        .flu_result_i      (flu_result_o),
        .flu_trans_id_i    (flu_trans_id_o),
        .flu_valid_i       (flu_valid_o),
        .flu_ready_i       (flu_ready_o),
        .flu_exception_i   (flu_exception_o),
        .resolved_branch_i (resolved_branch_o),
        .resolve_branch_i  (resolve_branch_o),
        .csr_addr_i        (csr_addr_o),
        .error_count_o     (error_count),
        .check_count_o     (check_count)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // Random source, x^16 + x^14 + x^13 + x^11
    // --------------------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = {value[30:0], lfsr_q[0]};
        end
    endtask

    task automatic randomize_operands();
        logic [31:0] bits;
        take_bits(32, bits);
        fu_data_i.operand_a = bits;
        take_bits(32, bits);
        fu_data_i.operand_b = bits;
        take_bits(32, bits);
        fu_data_i.imm = bits;
        take_bits(3, bits);
        fu_data_i.trans_id = bits[2:0];
        take_bits(31, bits);
        pc_i = {bits[30:0], 1'b0};
        take_bits(1, bits);
        is_compressed_i = bits[0];
        take_bits(1, bits);
        branch_predict_i.taken = bits[0];
        take_bits(32, bits);
        branch_predict_i.predict_address = bits;
    endtask

    task automatic clear_strobes();
        alu_valid_i    = 1'b0;
        branch_valid_i = 1'b0;
        csr_valid_i    = 1'b0;
        csr_commit_i   = 1'b0;
        flush_i        = 1'b0;
    endtask

    task automatic issue_alu();
        logic [31:0] bits;
        randomize_operands();
        take_bits(4, bits);
        fu_data_i.operator = fu_op_e'(5'(bits % 10));
        alu_valid_i = 1'b1;
    endtask

    task automatic issue_branch();
        logic [31:0] bits;
        randomize_operands();
        take_bits(3, bits);
        fu_data_i.operator = fu_op_e'(5'(int'(EQ) + int'(bits % 7)));
        // Equal operands now and then so EQ and GE paths get taken
        take_bits(2, bits);
        if (bits[1:0] == 2'd0) begin
            fu_data_i.operand_b = fu_data_i.operand_a;
        end
        // Branch offsets are always even
        if (fu_data_i.operator != JALR) begin
            fu_data_i.imm[0] = 1'b0;
        end
        take_bits(1, bits);
        if (bits[0]) begin
            if (fu_data_i.operator == JALR) begin
                branch_predict_i.predict_address =
                    (fu_data_i.operand_a + fu_data_i.imm) & ~`EXU_XLEN'd1;
            end else begin
                branch_predict_i.predict_address = pc_i + fu_data_i.imm;
            end
        end
        branch_valid_i = 1'b1;
    endtask

    task automatic issue_csr();
        logic [31:0] bits;
        randomize_operands();
        fu_data_i.operator = CSR_RW;
        csr_valid_i = 1'b1;
        take_bits(2, bits);
        hold_cnt    = int'(bits[1:0]);
        csr_pending = 1'b1;
    endtask

    // Ready must come back one cycle after commit or flush
    task automatic wait_for_ready();
        int waited;
        waited = 0;
        do begin
            @(posedge clk_i);
            #1;
            csr_commit_i = 1'b0;
            flush_i      = 1'b0;
            waited++;
        end while (!flu_ready_o && waited < READY_TIMEOUT);
        if (!flu_ready_o) begin
            $display("Timeout: flu_ready_o still low %0d cycles after commit or flush", waited);
            timed_out = 1'b1;
        end
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        logic [31:0] pick;
        lfsr_q           = 16'd17;
        rst_ni           = 1'b0;
        fu_data_i        = '0;
        pc_i             = '0;
        is_compressed_i  = 1'b0;
        branch_predict_i = '0;
        csr_pending      = 1'b0;
        timed_out        = 1'b0;
        hold_cnt         = 0;
        clear_strobes();
        repeat (2) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        for (int cycle = 0; cycle < NUM_CYCLES && !timed_out; cycle++) begin
            @(posedge clk_i);
            #1;
            clear_strobes();
            if (csr_pending) begin
                if (hold_cnt == 0) begin
                    take_bits(1, pick);
                    if (pick[0]) begin
                        csr_commit_i = 1'b1;
                    end else begin
                        flush_i = 1'b1;
                    end
                    csr_pending = 1'b0;
                    wait_for_ready();
                end else begin
                    hold_cnt--;
                end
            end else if (flu_ready_o) begin
                take_bits(3, pick);
                case (pick[2:0])
                    3'd0, 3'd1, 3'd2: issue_alu();
                    3'd3, 3'd4:       issue_branch();
                    3'd5:             issue_csr();
                    default:          clear_strobes();
                endcase
            end
        end

        @(posedge clk_i);
        #1;
        clear_strobes();
        @(posedge clk_i);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+hw
hw/exu_pkg.sv
hw/exu_alu.sv
hw/exu_branch_unit.sv
hw/exu_csr_buffer.sv
hw/exu_result_mux.sv
hw/exu_stage.sv
bench/exu_checker.sv
bench/tb_exu_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the execute-stage testbench with Verilator, run it and judge the log.

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log
TOP=tb_exu_stage

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module "$TOP" -Mdir "$BUILD_DIR" -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Done: no errors" "$LOG_FILE"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG_FILE"
    exit 1
fi
